//--- icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// fetch and memory address width
`define ICACHE_ADDR_BITS   32

// address split: tag [31:15], set [14:6], byte offset [5:0]
`define ICACHE_OFFSET_BITS 6
`define ICACHE_SET_BITS    9
`define ICACHE_TAG_BITS    17

// bank select sits just above the 16-byte bank offset
`define ICACHE_BANK_LSB    4
`define ICACHE_BANKS       4

// associativity
`define ICACHE_WAYS        2

// payload sizes
`define ICACHE_FETCH_BITS  128  // one bank
`define ICACHE_LINE_BITS   512  // one 64-byte line

`endif

//--- icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]  tag_t;
    typedef logic [`ICACHE_SET_BITS-1:0]  set_index_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

    // one way's tag entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // way 0 in the low bits
    typedef tag_entry_t [`ICACHE_WAYS-1:0] tag_row_t;

    typedef logic [`ICACHE_FETCH_BITS-1:0] fetch_data_t;

    // bank 0 in the low bits
    typedef fetch_data_t [`ICACHE_LINE_BITS/`ICACHE_FETCH_BITS-1:0] line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,      // tag row available, hit or miss decided
        READ_CACHE,  // line read back from the data store
        READ_MEM,    // line request on the memory bus
        REFILL       // write line and tag, answer the fetch
    } cache_state_t;

endpackage

//--- cache_sram.sv
`timescale 1ns/100ps

module cache_sram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 512
) (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     read_en,
    input  logic [$clog2(DEPTH)-1:0] read_addr,
    input  logic                     write_en,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  entry_t                   write_data,
    output entry_t                   read_data
);

    entry_t mem [DEPTH];

    // write port, whole array comes up cleared
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read, holds the last word between reads
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data <= '0;
        end else if (read_en) begin
            read_data <= mem[read_addr];  // old data on a same-address write
        end
    end

endmodule

//--- way_select.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module way_select
    import icache_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  tag_row_t tag_row,
    input  tag_t     lookup_tag,
    output logic     hit,
    output way_t     hit_way,
    output way_t     victim_way
);

    logic [7:0]              lfsr;
    logic                    lfsr_fb;
    logic [`ICACHE_WAYS-1:0] way_hit;
    logic [`ICACHE_WAYS-1:0] way_valid;

    // per-way compare
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_valid[w] = tag_row[w].valid;
            way_hit[w]   = tag_row[w].valid && (tag_row[w].tag == lookup_tag);
        end
    end

    assign hit = |way_hit;

    // encode hit way, lowest way wins
    always_comb begin
        hit_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // first invalid way, random pick once the set is full
    always_comb begin
        victim_way = lfsr[$bits(way_t)-1:0];
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    // taps 8,6,5,4
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= 8'hff;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};  // free running
        end
    end

endmodule

//--- icache_ctrl.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic                                  flush,
    // fetch port
    input  logic                                  fetch_valid,
    input  addr_t                                 fetch_addr,
    output logic                                  fetch_ready,
    output logic                                  fetch_done,
    output fetch_data_t                           fetch_data,
    // memory bus
    output logic                                  mem_req,
    output addr_t                                 mem_addr,
    input  logic                                  mem_ready,
    input  logic                                  mem_done,
    input  line_t                                 mem_rdata,
    // tag array
    output logic                                  tag_read_en,
    output set_index_t                            tag_read_addr,
    input  tag_row_t                              tag_rdata,
    output logic                                  tag_write_en,
    output set_index_t                            tag_write_addr,
    output tag_row_t                              tag_wdata,
    // way selector
    output tag_t                                  lookup_tag,
    input  logic                                  hit,
    input  way_t                                  hit_way,
    input  way_t                                  victim_way,
    // line array, addressed by {set, way}
    output logic                                  line_read_en,
    output logic [`ICACHE_SET_BITS+$bits(way_t)-1:0] line_read_addr,
    input  line_t                                 line_rdata,
    output logic                                  line_write_en,
    output logic [`ICACHE_SET_BITS+$bits(way_t)-1:0] line_write_addr,
    output line_t                                 line_wdata
);

    localparam int BANK_SEL_BITS = $clog2(`ICACHE_BANKS);

    cache_state_t             state;
    cache_state_t             next_state;
    addr_t                    req_addr;
    set_index_t               req_set;
    logic [BANK_SEL_BITS-1:0] req_bank;
    tag_row_t                 tag_row_q;
    way_t                     victim_q;
    line_t                    line_buf;
    logic                     mem_pending;
    logic                     lookup_start;  // accepted, tag row read on the next edge
    logic                     fetch_fire;
    logic                     mem_fire;

    // no new request while a fired line read is still in flight
    assign fetch_ready = (state == IDLE) && !lookup_start && !mem_pending;
    assign fetch_fire  = fetch_valid && fetch_ready;
    assign mem_fire    = mem_req && mem_ready;

    assign req_set    = req_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign req_bank   = req_addr[`ICACHE_BANK_LSB +: BANK_SEL_BITS];
    assign lookup_tag = req_addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];

    always_ff @(posedge clock) begin
        if (fetch_fire) begin
            req_addr <= fetch_addr;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lookup_start <= 1'b0;
        end else if (flush) begin
            lookup_start <= 1'b0;
        end else begin
            lookup_start <= fetch_fire;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;  // drops the request in progress
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (lookup_start) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                next_state = hit ? READ_CACHE : READ_MEM;
            end
            READ_CACHE: begin
                next_state = IDLE;
            end
            READ_MEM: begin
                if (mem_done) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // victim and tag row are frozen at lookup, lfsr keeps running
    always_ff @(posedge clock) begin
        if (state == LOOKUP) begin
            tag_row_q <= tag_rdata;
            victim_q  <= victim_way;
        end
        if ((state == READ_MEM) && mem_done) begin
            line_buf <= mem_rdata;
        end
    end

    // line request, held until mem_ready
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_req  <= 1'b0;
            mem_addr <= '0;
        end else if (flush || mem_fire) begin
            mem_req <= 1'b0;
        end else if ((state == LOOKUP) && !hit) begin
            mem_req  <= 1'b1;
            mem_addr <= {req_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                         {`ICACHE_OFFSET_BITS{1'b0}}};  // line aligned
        end
    end

    // fire to done, survives a flush
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_pending <= 1'b0;
        end else if (mem_fire) begin
            mem_pending <= 1'b1;
        end else if (mem_done) begin
            mem_pending <= 1'b0;
        end
    end

    assign tag_read_en   = lookup_start;
    assign tag_read_addr = req_set;

    // refill updates the victim entry only
    always_comb begin
        tag_wdata                 = tag_row_q;
        tag_wdata[victim_q].valid = 1'b1;
        tag_wdata[victim_q].tag   = lookup_tag;
    end

    assign tag_write_en   = (state == REFILL);
    assign tag_write_addr = req_set;

    assign line_read_en    = (state == LOOKUP) && hit;
    assign line_read_addr  = {req_set, hit_way};
    assign line_write_en   = (state == REFILL);
    assign line_write_addr = {req_set, victim_q};
    assign line_wdata      = line_buf;

    assign fetch_done = ((state == READ_CACHE) || (state == REFILL)) && !flush;
    assign fetch_data = (state == REFILL) ? line_buf[req_bank] : line_rdata[req_bank];

endmodule

//--- icache_top.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        flush,
    input  logic        fetch_valid,
    input  addr_t       fetch_addr,
    output logic        fetch_ready,
    output logic        fetch_done,
    output fetch_data_t fetch_data,
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_ready,
    input  logic        mem_done,
    input  line_t       mem_rdata
);

    logic       tag_read_en;
    set_index_t tag_read_addr;
    tag_row_t   tag_rdata;
    logic       tag_write_en;
    set_index_t tag_write_addr;
    tag_row_t   tag_wdata;
    tag_t       lookup_tag;
    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    logic       line_read_en;
    logic [`ICACHE_SET_BITS+$bits(way_t)-1:0] line_read_addr;
    line_t      line_rdata;
    logic       line_write_en;
    logic [`ICACHE_SET_BITS+$bits(way_t)-1:0] line_write_addr;
    line_t      line_wdata;

    icache_ctrl i_ctrl (.*);

    way_select i_way_select (
        .clock      (clock),
        .reset_n    (reset_n),
        .tag_row    (tag_rdata),
        .lookup_tag (lookup_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    // one row per set, both ways side by side
    cache_sram #(
        .entry_t (tag_row_t),
        .DEPTH   (1 << `ICACHE_SET_BITS)
    ) i_tag_ram (
        .clock      (clock),
        .reset_n    (reset_n),
        .read_en    (tag_read_en),
        .read_addr  (tag_read_addr),
        .write_en   (tag_write_en),
        .write_addr (tag_write_addr),
        .write_data (tag_wdata),
        .read_data  (tag_rdata)
    );

    cache_sram #(
        .entry_t (line_t),
        .DEPTH   (1 << (`ICACHE_SET_BITS + $bits(way_t)))
    ) i_line_ram (
        .clock      (clock),
        .reset_n    (reset_n),
        .read_en    (line_read_en),
        .read_addr  (line_read_addr),
        .write_en   (line_write_en),
        .write_addr (line_write_addr),
        .write_data (line_wdata),
        .read_data  (line_rdata)
    );

endmodule

//--- icache_asserts.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_asserts
    import icache_pkg::*;
(
    input logic  clock,
    input logic  reset_n,
    input logic  flush,
    input logic  fetch_valid,
    input logic  fetch_ready,
    input logic  fetch_done,
    input logic  mem_req,
    input addr_t mem_addr,
    input logic  mem_ready
);

    int   failure_count = 0;
    logic seen_accept;  // a fetch was accepted since reset

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            seen_accept <= 1'b0;
        end else if (fetch_valid && fetch_ready) begin
            seen_accept <= 1'b1;
        end
    end

    // only a flush may withdraw a waiting request
    req_stable: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req && !mem_ready && !flush |=> mem_req && $stable(mem_addr))
    else begin
        failure_count++;
        $error("mem_req or mem_addr changed before mem_ready");
    end

    addr_aligned: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req |-> (mem_addr[`ICACHE_OFFSET_BITS-1:0] == '0))
    else begin
        failure_count++;
        $error("mem_addr is not line aligned");
    end

    done_not_ready: assert property (@(posedge clock) disable iff (!reset_n)
        fetch_done |-> !fetch_ready)
    else begin
        failure_count++;
        $error("fetch_done while fetch_ready is high");
    end

    no_early_done: assert property (@(posedge clock) disable iff (!reset_n)
        !seen_accept |-> !fetch_done)
    else begin
        failure_count++;
        $error("fetch_done before any fetch was accepted");
    end

endmodule

bind icache_top icache_asserts i_asserts (.*);

//--- icache_tb.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int HIT_LATENCY    = 3;   // accept edge to fetch_done edge
    localparam int RANDOM_FETCHES = 40;

    logic        clock;
    logic        reset_n;
    logic        flush;
    logic        fetch_valid;
    addr_t       fetch_addr;
    logic        fetch_ready;
    logic        fetch_done;
    fetch_data_t fetch_data;
    logic        mem_req;
    addr_t       mem_addr;
    logic        mem_ready;
    logic        mem_done;
    line_t       mem_rdata;

    integer      seed = 35;
    int          cycle_count = 0;
    int          done_count = 0;
    int          fire_count = 0;
    int          stall_cycles = 0;  // extra mem_ready delay for the next request
    int          last_accept_edge;
    int          last_done_edge;
    int          mem_done_edge;
    addr_t       last_mem_addr;
    fetch_data_t expect_q [$];

    icache_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // edge index, read by every process before it moves
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // each 32-bit word is its own byte address xor a fixed pattern
    function automatic fetch_data_t reference_bank(input addr_t addr);
        fetch_data_t bank;
        addr_t       base;
        base = {addr[`ICACHE_ADDR_BITS-1:`ICACHE_BANK_LSB], {`ICACHE_BANK_LSB{1'b0}}};
        for (int w = 0; w < `ICACHE_FETCH_BITS / 32; w++) begin
            bank[32*w +: 32] = (base + addr_t'(4 * w)) ^ 32'h5a5a_0000;
        end
        return bank;
    endfunction

    function automatic line_t reference_line(input addr_t line_addr);
        line_t line;
        for (int b = 0; b < `ICACHE_BANKS; b++) begin
            line[b] = reference_bank(line_addr + addr_t'(b * `ICACHE_FETCH_BITS / 8));
        end
        return line;
    endfunction

    function automatic addr_t make_addr(input tag_t tag, input set_index_t set,
                                        input logic [1:0] bank, input logic [3:0] byte_off);
        return {tag, set, bank, byte_off};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // memory side, random ready delay then random done delay
    initial begin : memory_model
        int    wait_cycles;
        addr_t line_addr;
        mem_ready = 1'b0;
        mem_done  = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clock);
            if (mem_req) begin
                wait_cycles  = stall_cycles + ($unsigned($random(seed)) % 4);
                stall_cycles = 0;
                while ((wait_cycles > 0) && mem_req) begin
                    @(negedge clock);
                    wait_cycles--;
                end
                if (mem_req) begin  // still requested, fire on the next edge
                    mem_ready     = 1'b1;
                    line_addr     = mem_addr;
                    last_mem_addr = mem_addr;
                    fire_count++;
                    @(negedge clock);
                    mem_ready   = 1'b0;
                    wait_cycles = 1 + ($unsigned($random(seed)) % 5);
                    repeat (wait_cycles - 1) @(negedge clock);
                    mem_done      = 1'b1;
                    mem_rdata     = reference_line(line_addr);
                    mem_done_edge = cycle_count;  // edge that samples mem_done
                    @(negedge clock);
                    mem_done = 1'b0;
                end
            end
        end
    end

    // compare every response with the oldest expectation
    always @(posedge clock) begin : compare_responses
        fetch_data_t expected;
        if (reset_n && fetch_done) begin
            if (expect_q.size() == 0) begin
                fail_run("fetch_done arrived with no request outstanding");
            end else begin
                expected = expect_q.pop_front();
                check_value("fetch_data", fetch_data, expected);
                last_done_edge = cycle_count;
                done_count++;
            end
        end
    end

    task automatic issue_request(input addr_t addr, input logic expect_response);
        int   timeout;
        logic accepted;
        timeout  = 0;
        accepted = 1'b0;
        @(negedge clock);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        while (!accepted) begin
            @(posedge clock);
            if (fetch_ready) begin
                accepted         = 1'b1;
                last_accept_edge = cycle_count;
                if (expect_response) begin
                    expect_q.push_back(reference_bank(addr));
                end
            end else begin
                timeout++;
                if (timeout > TIMEOUT_CYCLES) begin
                    fail_run("fetch request was never accepted");
                end
            end
        end
        @(negedge clock);
        fetch_valid = 1'b0;
    endtask

    task automatic wait_for_done(input int target);
        int timeout;
        timeout = 0;
        while (done_count < target) begin
            @(negedge clock);
            timeout++;
            if (timeout > TIMEOUT_CYCLES) begin
                fail_run("no fetch_done arrived within the time limit");
            end
        end
    endtask

    // expected_fires below zero means hit or miss is not known
    task automatic do_fetch(input addr_t addr, input int expected_fires);
        int fires_before;
        int target;
        fires_before = fire_count;
        target       = done_count + 1;
        issue_request(addr, 1'b1);
        wait_for_done(target);
        if (expected_fires >= 0) begin
            check_value("memory request count", fire_count - fires_before, expected_fires);
        end
        if (fire_count != fires_before) begin
            check_value("mem_addr", last_mem_addr,
                        {addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                         {`ICACHE_OFFSET_BITS{1'b0}}});
            check_value("miss fetch_done edge", last_done_edge, mem_done_edge + 1);
        end else begin
            check_value("hit fetch_done latency", last_done_edge - last_accept_edge,
                        HIT_LATENCY);
        end
    endtask

    task automatic run_random_fetches(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            // four tags over four sets, so the lfsr has to pick victims
            do_fetch(make_addr({15'h0, rnd[1:0]}, {7'h20, rnd[3:2]}, rnd[5:4], rnd[9:6]), -1);
        end
    endtask

    // flush a miss before or after its line request fired
    task automatic flush_miss(input addr_t addr, input logic after_fire);
        int timeout;
        int start_done;
        start_done = done_count;
        timeout    = 0;
        if (!after_fire) begin
            stall_cycles = 8;
        end
        issue_request(addr, 1'b0);
        while (!mem_req) begin
            @(negedge clock);
            timeout++;
            if (timeout > TIMEOUT_CYCLES) begin
                fail_run("mem_req never rose for the miss to be flushed");
            end
        end
        while (after_fire && mem_req) begin  // drops at the fire
            @(negedge clock);
            timeout++;
            if (timeout > TIMEOUT_CYCLES) begin
                fail_run("memory request never fired before the flush");
            end
        end
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        while (!fetch_ready) begin
            @(negedge clock);
            timeout++;
            if (timeout > TIMEOUT_CYCLES) begin
                fail_run("fetch_ready did not return after the flush");
            end
        end
        check_value("fetch_done count after flush", done_count, start_done);
        do_fetch(addr, 1);  // line was never written, so it misses again
    endtask

    initial begin : stimulus
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        reset_n     = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        // cold miss, then the rest of the line hits
        do_fetch(make_addr(17'h00123, 9'h045, 2'd1, 4'h0), 1);
        for (int b = 0; b < `ICACHE_BANKS; b++) begin
            if (b != 1) begin
                do_fetch(make_addr(17'h00123, 9'h045, 2'(b), 4'h8), 0);
            end
        end

        // second tag in the set takes the free way
        do_fetch(make_addr(17'h00456, 9'h045, 2'd0, 4'h0), 1);
        do_fetch(make_addr(17'h00123, 9'h045, 2'd3, 4'h0), 0);
        do_fetch(make_addr(17'h00456, 9'h045, 2'd2, 4'h4), 0);

        // third tag evicts one of them
        do_fetch(make_addr(17'h00789, 9'h045, 2'd1, 4'h0), 1);
        do_fetch(make_addr(17'h00789, 9'h045, 2'd3, 4'hc), 0);
        run_random_fetches(RANDOM_FETCHES);

        stall_cycles = 6;  // slow memory
        do_fetch(make_addr(17'h01abc, 9'h010, 2'd2, 4'h4), 1);

        flush_miss(make_addr(17'h00321, 9'h1f0, 2'd1, 4'h0), 1'b0);
        flush_miss(make_addr(17'h00654, 9'h1f1, 2'd0, 4'h0), 1'b1);

        repeat (4) @(negedge clock);
        if ((expect_q.size() == 0) && (i_dut.i_asserts.failure_count == 0)) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("responses missing or protocol assertions failed during the run");
        end
    end

endmodule

//--- sim.f
+incdir+.
icache_pkg.sv
cache_sram.sv
way_select.sv
icache_ctrl.sv
icache_top.sv
icache_asserts.sv
icache_tb.sv
